// File: Bender.yml
package:
  name: ps_ctrl

sources:
  - files:
      - common/ps_ctrl_pkg.sv
      - axi_lite/axi_write_ctrl.sv
      - axi_lite/axi_read_ctrl.sv
      - regs/ap_ctrl_regs.sv
      - regs/user_reg_bank.sv
      - verilog/ps_ctrl_top.sv

  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_ps_ctrl.sv

// File: axi_lite/axi_read_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module axi_read_ctrl (
    input  wire                clk,
    input  wire                rst_n,
    input  wire                arvalid,
    output logic               arready,
    input  ps_ctrl_pkg::addr_t araddr,
    output logic               rvalid,
    input  wire                rready,
    output ps_ctrl_pkg::word_t rdata,
    output logic [1:0]         rresp,
    output logic               ctrl_read_pulse,
    input  ps_ctrl_pkg::word_t ctrl_word,
    input  ps_ctrl_pkg::word_t gie_word,
    input  ps_ctrl_pkg::word_t ier_word,
    input  ps_ctrl_pkg::word_t isr_word,
    input  ps_ctrl_pkg::word_t [ps_ctrl_pkg::NUM_INSTR_WORDS-1:0]  instr_words,
    input  ps_ctrl_pkg::word_t [ps_ctrl_pkg::NUM_CORE_SCALARS-1:0] core_words,
    input  ps_ctrl_pkg::word_t aux_instr_status,
    input  ps_ctrl_pkg::word_t [ps_ctrl_pkg::NUM_CORE_STATUS-1:0]  core_status
);
    import ps_ctrl_pkg::*;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_DATA,
        RD_RESET
    } rd_state_e;

    rd_state_e state;
    rd_state_e state_next;
    logic      ar_hs;
    word_t     rd_word;

    assign arready = (state == RD_IDLE);
    assign rvalid  = (state == RD_DATA);
    assign rresp   = bresp_okay;
    assign ar_hs   = arvalid && arready;

    // clears ap_done in the control register
    assign ctrl_read_pulse = ar_hs && (araddr == ADDR_AP_CTRL);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= RD_RESET;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            RD_IDLE: if (arvalid) state_next = RD_DATA;
            RD_DATA: if (rready) state_next = RD_IDLE;
            default: state_next = RD_IDLE;
        endcase
    end

    // read mux, reserved addresses give zero
    always_comb begin
        case (araddr)
            ADDR_AP_CTRL:       rd_word = ctrl_word;
            ADDR_GIE:           rd_word = gie_word;
            ADDR_IER:           rd_word = ier_word;
            ADDR_ISR:           rd_word = isr_word;
            ADDR_INSTR_SCALAR:  rd_word = instr_words[0];
            ADDR_INSTR_ADDR_L:  rd_word = instr_words[1];
            ADDR_INSTR_ADDR_H:  rd_word = instr_words[2];
            ADDR_INSTR_STATUS:  rd_word = aux_instr_status;
            ADDR_CORE_SCALAR_0: rd_word = core_words[0];
            ADDR_CORE_SCALAR_1: rd_word = core_words[1];
            ADDR_CORE_SCALAR_2: rd_word = core_words[2];
            ADDR_CORE_SCALAR_3: rd_word = core_words[3];
            ADDR_CORE_STATUS_0: rd_word = core_status[0];
            ADDR_CORE_STATUS_1: rd_word = core_status[1];
            default:            rd_word = '0;
        endcase
    end

    // held through rready back-pressure
    always_ff @(posedge clk) begin
        if (ar_hs) begin
            rdata <= rd_word;
        end
    end

endmodule

`default_nettype wire

// File: axi_lite/axi_write_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module axi_write_ctrl (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   awvalid,
    output logic                  awready,
    input  ps_ctrl_pkg::addr_t    awaddr,
    input  wire                   wvalid,
    output logic                  wready,
    input  ps_ctrl_pkg::word_t    wdata,
    input  ps_ctrl_pkg::strb_t    wstrb,
    output logic                  bvalid,
    input  wire                   bready,
    output logic [1:0]            bresp,
    output logic                  wr_en,
    output ps_ctrl_pkg::reg_sel_e wr_sel,
    output ps_ctrl_pkg::word_t    wr_data,
    output ps_ctrl_pkg::strb_t    wr_strb
);
    import ps_ctrl_pkg::*;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_DATA,
        WR_RESP,
        WR_RESET
    } wr_state_e;

    wr_state_e state;
    wr_state_e state_next;
    addr_t     waddr;

    assign awready = (state == WR_IDLE);
    assign wready  = (state == WR_DATA);
    assign bvalid  = (state == WR_RESP);
    assign bresp   = bresp_okay;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= WR_RESET;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            WR_IDLE: if (awvalid) state_next = WR_DATA;
            WR_DATA: if (wvalid) state_next = WR_RESP;
            WR_RESP: if (bready) state_next = WR_IDLE;
            default: state_next = WR_IDLE;
        endcase
    end

    // address held from AW until the W beat
    always_ff @(posedge clk) begin
        if (awvalid && awready) begin
            waddr <= awaddr;
        end
    end

    // read-only and reserved addresses decode to SEL_NONE
    always_comb begin
        case (waddr)
            ADDR_AP_CTRL:       wr_sel = SEL_AP_CTRL;
            ADDR_GIE:           wr_sel = SEL_GIE;
            ADDR_IER:           wr_sel = SEL_IER;
            ADDR_ISR:           wr_sel = SEL_ISR;
            ADDR_INSTR_SCALAR:  wr_sel = SEL_INSTR_SCALAR;
            ADDR_INSTR_ADDR_L:  wr_sel = SEL_INSTR_ADDR_L;
            ADDR_INSTR_ADDR_H:  wr_sel = SEL_INSTR_ADDR_H;
            ADDR_CORE_SCALAR_0: wr_sel = SEL_CORE_SCALAR_0;
            ADDR_CORE_SCALAR_1: wr_sel = SEL_CORE_SCALAR_1;
            ADDR_CORE_SCALAR_2: wr_sel = SEL_CORE_SCALAR_2;
            ADDR_CORE_SCALAR_3: wr_sel = SEL_CORE_SCALAR_3;
            default:            wr_sel = SEL_NONE;
        endcase
    end

    assign wr_en   = wvalid && wready;
    assign wr_data = wdata;
    assign wr_strb = wstrb;

endmodule

`default_nettype wire

// File: common/ps_ctrl_pkg.sv
`default_nettype none

package ps_ctrl_pkg;

    // bus widths
    localparam int ADDR_W = 8;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;

    typedef logic [ADDR_W-1:0]   addr_t;
    typedef logic [DATA_W-1:0]   word_t;
    typedef logic [STRB_W-1:0]   strb_t;
    typedef logic [2*DATA_W-1:0] addr64_t;

    // register map
    localparam addr_t ADDR_AP_CTRL       = 8'h00;
    localparam addr_t ADDR_GIE           = 8'h04;
    localparam addr_t ADDR_IER           = 8'h08;
    localparam addr_t ADDR_ISR           = 8'h0c;
    localparam addr_t ADDR_INSTR_SCALAR  = 8'h10;
    localparam addr_t ADDR_INSTR_ADDR_L  = 8'h14;
    localparam addr_t ADDR_INSTR_ADDR_H  = 8'h18;
    localparam addr_t ADDR_INSTR_STATUS  = 8'h1c;
    localparam addr_t ADDR_CORE_SCALAR_0 = 8'h30;
    localparam addr_t ADDR_CORE_SCALAR_1 = 8'h34;
    localparam addr_t ADDR_CORE_SCALAR_2 = 8'h38;
    localparam addr_t ADDR_CORE_SCALAR_3 = 8'h3c;
    localparam addr_t ADDR_CORE_STATUS_0 = 8'h40;
    localparam addr_t ADDR_CORE_STATUS_1 = 8'h44;

    // decoded write target, banks rely on consecutive values
    typedef enum logic [3:0] {
        SEL_NONE,
        SEL_AP_CTRL,
        SEL_GIE,
        SEL_IER,
        SEL_ISR,
        SEL_INSTR_SCALAR,
        SEL_INSTR_ADDR_L,
        SEL_INSTR_ADDR_H,
        SEL_CORE_SCALAR_0,
        SEL_CORE_SCALAR_1,
        SEL_CORE_SCALAR_2,
        SEL_CORE_SCALAR_3
    } reg_sel_e;

    // control register layout
    localparam int CTRL_START_BIT        = 0;
    localparam int CTRL_DONE_BIT         = 1;
    localparam int CTRL_IDLE_BIT         = 2;
    localparam int CTRL_READY_BIT        = 3;
    localparam int CTRL_AUTO_RESTART_BIT = 7;

    localparam int NUM_INSTR_WORDS  = 3;
    localparam int NUM_CORE_SCALARS = 4;
    localparam int NUM_CORE_STATUS  = 2;

    // word 0 scalar, word 1 addr low, word 2 addr high
    localparam word_t [NUM_INSTR_WORDS-1:0] INSTR_RESET_WORDS = {
        32'h0000_0000,
        32'hAAAA_0000,
        32'hAAAA_0000
    };

    localparam logic [1:0] bresp_okay = 2'b00;

endpackage

`default_nettype wire

// File: regs/ap_ctrl_regs.sv
`timescale 1ns/1ps
`default_nettype none

module ap_ctrl_regs (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   wr_en,
    input  ps_ctrl_pkg::reg_sel_e wr_sel,
    input  ps_ctrl_pkg::word_t    wr_data,
    input  ps_ctrl_pkg::strb_t    wr_strb,
    input  wire                   ctrl_read_pulse,
    input  wire                   ap_done,
    input  wire                   ap_idle,
    input  wire                   ap_ready,
    output logic                  ap_start,
    output logic                  interrupt,
    output ps_ctrl_pkg::word_t    ctrl_word,
    output ps_ctrl_pkg::word_t    gie_word,
    output ps_ctrl_pkg::word_t    ier_word,
    output ps_ctrl_pkg::word_t    isr_word
);
    import ps_ctrl_pkg::*;

    logic       done_q;
    logic       idle_q;
    logic       ready_q;
    logic       auto_restart;
    logic       gie;
    logic [1:0] ier;
    logic [1:0] isr;
    logic [1:0] isr_set;
    logic       ctrl_wr;
    logic       gie_wr;
    logic       ier_wr;
    logic       isr_wr;

    // all of these only look at byte 0
    assign ctrl_wr = wr_en && wr_strb[0] && (wr_sel == SEL_AP_CTRL);
    assign gie_wr  = wr_en && wr_strb[0] && (wr_sel == SEL_GIE);
    assign ier_wr  = wr_en && wr_strb[0] && (wr_sel == SEL_IER);
    assign isr_wr  = wr_en && wr_strb[0] && (wr_sel == SEL_ISR);

    // bit 0 ap_done, bit 1 ap_ready
    assign isr_set = ier & {ap_ready, ap_done};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ap_start     <= 1'b0;
            done_q       <= 1'b0;
            idle_q       <= 1'b0;
            ready_q      <= 1'b0;
            auto_restart <= 1'b0;
            gie          <= 1'b0;
            ier          <= 2'b00;
            isr          <= 2'b00;
        end else begin
            // a start write beats the clear from ap_done
            if (ctrl_wr && wr_data[CTRL_START_BIT]) begin
                ap_start <= 1'b1;
            end else if (ap_done) begin
                ap_start <= auto_restart;
            end
            // clear on read unless done arrives in the same cycle
            if (ap_done) begin
                done_q <= 1'b1;
            end else if (ctrl_read_pulse) begin
                done_q <= 1'b0;
            end
            idle_q  <= ap_idle;
            ready_q <= ap_ready;
            if (ctrl_wr) begin
                auto_restart <= wr_data[CTRL_AUTO_RESTART_BIT];
            end
            if (gie_wr) begin
                gie <= wr_data[0];
            end
            if (ier_wr) begin
                ier <= wr_data[1:0];
            end
            // toggle on write, an event set wins
            if (isr_wr) begin
                isr <= (isr ^ wr_data[1:0]) | isr_set;
            end else begin
                isr <= isr | isr_set;
            end
        end
    end

    assign interrupt = gie && (|isr);

    always_comb begin
        ctrl_word                        = '0;
        ctrl_word[CTRL_START_BIT]        = ap_start;
        ctrl_word[CTRL_DONE_BIT]         = done_q;
        ctrl_word[CTRL_IDLE_BIT]         = idle_q;
        ctrl_word[CTRL_READY_BIT]        = ready_q;
        ctrl_word[CTRL_AUTO_RESTART_BIT] = auto_restart;
    end

    assign gie_word = word_t'(gie);
    assign ier_word = word_t'(ier);
    assign isr_word = word_t'(isr);

endmodule

`default_nettype wire

// File: regs/user_reg_bank.sv
`timescale 1ns/1ps
`default_nettype none

module user_reg_bank #(
    parameter int                                 NUM_WORDS   = 1,
    parameter ps_ctrl_pkg::reg_sel_e              FIRST_SEL   = ps_ctrl_pkg::SEL_NONE,
    parameter ps_ctrl_pkg::word_t [NUM_WORDS-1:0] RESET_WORDS = '0
) (
    input  wire                                 clk,
    input  wire                                 rst_n,
    input  wire                                 wr_en,
    input  ps_ctrl_pkg::reg_sel_e               wr_sel,
    input  ps_ctrl_pkg::word_t                  wr_data,
    input  ps_ctrl_pkg::strb_t                  wr_strb,
    output ps_ctrl_pkg::word_t [NUM_WORDS-1:0]  words
);
    import ps_ctrl_pkg::*;

    // word i answers to select value FIRST_SEL + i
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            words <= RESET_WORDS;
        end else if (wr_en) begin
            for (int i = 0; i < NUM_WORDS; i++) begin
                if (int'(wr_sel) == int'(FIRST_SEL) + i) begin
                    // only strobed bytes change
                    for (int b = 0; b < STRB_W; b++) begin
                        if (wr_strb[b]) begin
                            words[i][8*b +: 8] <= wr_data[8*b +: 8];
                        end
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: sim/ps_ctrl_cases.txt
# op addr data strb name expected, all hex except op and name
# ops wr rd done ready stat chk; stat 00 drives ap_idle, chk 00 is ap_start, chk 0c is interrupt
rd    10 00000000 0 rst_instr_scalar   aaaa0000
rd    14 00000000 0 rst_instr_addr_l   aaaa0000
rd    30 00000000 0 rst_core_scalar0   00000000
wr    10 12345678 3 wr_scalar_low      0
rd    10 00000000 0 rd_scalar_low      aaaa5678
chk   10 00000000 0 out_scalar         aaaa5678
wr    18 deadbeef c wr_addr_high       0
chk   14 00000000 0 out_instr_addr     dead0000aaaa0000
wr    34 cafef00d f wr_core1           0
rd    34 00000000 0 rd_core1           cafef00d
stat  1c 13572468 0 set_instr_status   0
stat  44 89abcdef 0 set_core_status1   0
wr    1c ffffffff f wr_instr_status_ro 0
rd    1c 00000000 0 rd_instr_status    13572468
rd    44 00000000 0 rd_core_status1    89abcdef
wr    24 ffffffff f wr_reserved        0
rd    24 00000000 0 rd_reserved        00000000
stat  00 00000001 0 set_idle           0
rd    00 00000000 0 rd_ctrl_idle       00000004
wr    00 00000001 1 wr_start           0
chk   00 00000000 0 out_start_high     1
done  00 00000000 0 pulse_done         0
chk   00 00000000 0 out_start_cleared  0
rd    00 00000000 0 rd_ctrl_done       00000006
rd    00 00000000 0 rd_ctrl_done_clr   00000004
wr    00 00000081 1 wr_start_auto      0
done  00 00000000 0 pulse_done_auto    0
chk   00 00000000 0 out_start_kept     1
wr    08 00000003 1 wr_ier             0
wr    04 00000001 1 wr_gie             0
chk   0c 00000000 0 out_irq_quiet      0
ready 00 00000000 0 pulse_ready        0
chk   0c 00000000 0 out_irq_ready      1
rd    0c 00000000 0 rd_isr_ready       00000002
wr    0c 00000002 1 wr_isr_toggle      0
chk   0c 00000000 0 out_irq_cleared    0
wr    04 00000000 1 wr_gie_off         0
done  00 00000000 0 pulse_done_nogie   0
chk   0c 00000000 0 out_irq_masked     0
rd    0c 00000000 0 rd_isr_done        00000001
rd    00 00000000 0 rd_ctrl_auto       00000087

// File: sim/tb_ps_ctrl_tasks.svh
`ifndef TB_PS_CTRL_TASKS_SVH
`define TB_PS_CTRL_TASKS_SVH

task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
        $display("[ERROR] %s expected %h actual %h", name, exp, act);
        case_failed = 1'b1;
    end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
        $display("[ERROR] %s expected %b actual %b", name, exp, act);
        case_failed = 1'b1;
    end
endtask

task automatic check_addr(input string name, input addr64_t exp, input addr64_t act);
    if (act !== exp) begin
        $display("[ERROR] %s expected %h actual %h", name, exp, act);
        case_failed = 1'b1;
    end
endtask

// the case file and the model must agree before the DUT is judged
task automatic check_model(input string name, input addr64_t file_val, input addr64_t mdl_val);
    if (file_val !== mdl_val) begin
        $display("case file value for %s disagrees with the model, file %h model %h",
                 name, file_val, mdl_val);
        case_failed = 1'b1;
    end
endtask

task automatic axi_write(input string name, input addr_t addr, input word_t data,
                         input strb_t strb);
    int unsigned delay;
    delay = random_bits(3);
    @(posedge clk);
    awvalid <= 1'b1;
    awaddr  <= addr;
    @(negedge clk);
    while (!awready) @(negedge clk);
    @(posedge clk);
    awvalid <= 1'b0;
    wvalid  <= 1'b1;
    wdata   <= data;
    wstrb   <= strb;
    @(negedge clk);
    while (!wready) @(negedge clk);
    @(posedge clk);
    wvalid <= 1'b0;
    @(negedge clk);
    while (!bvalid) @(negedge clk);
    // bready held low for a random stretch
    repeat (delay) begin
        @(negedge clk);
        if (!bvalid) begin
            $display("bvalid dropped before bready in test %s", name);
            case_failed = 1'b1;
        end
    end
    check_word(name, word_t'(bresp_okay), word_t'(bresp));
    @(posedge clk);
    bready <= 1'b1;
    @(posedge clk);
    bready <= 1'b0;
endtask

task automatic axi_read(input string name, input addr_t addr, output word_t data);
    int unsigned delay;
    delay = random_bits(3);
    @(posedge clk);
    arvalid <= 1'b1;
    araddr  <= addr;
    @(negedge clk);
    while (!arready) @(negedge clk);
    @(posedge clk);
    arvalid <= 1'b0;
    @(negedge clk);
    while (!rvalid) @(negedge clk);
    data = rdata;
    repeat (delay) begin
        @(negedge clk);
        if (!rvalid || rdata !== data) begin
            $display("read data did not hold under rready back-pressure in test %s", name);
            case_failed = 1'b1;
        end
    end
    check_word(name, word_t'(bresp_okay), word_t'(rresp));
    @(posedge clk);
    rready <= 1'b1;
    @(posedge clk);
    rready <= 1'b0;
endtask

`endif

// File: sim/tb_ps_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ps_ctrl;
    import ps_ctrl_pkg::*;

    localparam int MAX_DELAY       = 7;
    localparam int CYCLES_PER_CASE = 40;

    logic    clk;
    logic    rst_n;
    logic    awvalid;
    logic    awready;
    addr_t   awaddr;
    logic    wvalid;
    logic    wready;
    word_t   wdata;
    strb_t   wstrb;
    logic    bvalid;
    logic    bready;
    logic [1:0] bresp;
    logic    arvalid;
    logic    arready;
    addr_t   araddr;
    logic    rvalid;
    logic    rready;
    word_t   rdata;
    logic [1:0] rresp;
    logic    ap_start;
    logic    ap_done;
    logic    ap_idle;
    logic    ap_ready;
    logic    interrupt;
    word_t   aux_instr_scalar;
    addr64_t aux_instr_addr;
    word_t   aux_instr_status;
    word_t [NUM_CORE_SCALARS-1:0] core_scalar;
    word_t [NUM_CORE_STATUS-1:0]  core_status;

    // cases as read from the file
    string   op_q[$];
    addr_t   addr_q[$];
    word_t   data_q[$];
    strb_t   strb_q[$];
    string   name_q[$];
    addr64_t exp_q[$];

    // reference model state
    logic       m_start;
    logic       m_done;
    logic       m_idle;
    logic       m_auto;
    logic       m_gie;
    logic [1:0] m_ier;
    logic [1:0] m_isr;
    word_t      m_instr[NUM_INSTR_WORDS];
    word_t      m_core[NUM_CORE_SCALARS];
    word_t      m_aux_status;
    word_t      m_core_status[NUM_CORE_STATUS];

    logic        case_failed;
    int          tests = 0;
    int          failures = 0;
    int          cycles = 0;
    int          cycle_limit = 0;
    logic [15:0] lfsr = 16'd18885;

    ps_ctrl_top i_ps_ctrl_top (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // one LFSR step per bit taken
    function automatic int unsigned random_bits(input int n);
        int unsigned v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = (v << 1) | lfsr[0];
        end
        return v;
    endfunction

    `include "tb_ps_ctrl_tasks.svh"

    function automatic word_t merge_bytes(input word_t old, input word_t data, input strb_t strb);
        word_t res;
        res = old;
        for (int b = 0; b < STRB_W; b++) begin
            if (strb[b]) res[8*b +: 8] = data[8*b +: 8];
        end
        return res;
    endfunction

    function automatic int core_index(input addr_t addr);
        return (addr - ADDR_CORE_SCALAR_0) >> 2;
    endfunction

    task automatic model_write(input addr_t addr, input word_t data, input strb_t strb);
        if (strb[0]) begin
            case (addr)
                ADDR_AP_CTRL: begin
                    if (data[CTRL_START_BIT]) m_start = 1'b1;
                    m_auto = data[CTRL_AUTO_RESTART_BIT];
                end
                ADDR_GIE: m_gie = data[0];
                ADDR_IER: m_ier = data[1:0];
                ADDR_ISR: m_isr = m_isr ^ data[1:0];
                default: ;
            endcase
        end
        if (addr >= ADDR_INSTR_SCALAR && addr <= ADDR_INSTR_ADDR_H) begin
            m_instr[(addr - ADDR_INSTR_SCALAR) >> 2] =
                merge_bytes(m_instr[(addr - ADDR_INSTR_SCALAR) >> 2], data, strb);
        end
        if (addr >= ADDR_CORE_SCALAR_0 && addr <= ADDR_CORE_SCALAR_3) begin
            m_core[core_index(addr)] = merge_bytes(m_core[core_index(addr)], data, strb);
        end
    endtask

    // control read also clears the done flag
    task automatic model_read(input addr_t addr, output word_t val);
        val = '0;
        case (addr)
            ADDR_AP_CTRL: begin
                val[CTRL_START_BIT]        = m_start;
                val[CTRL_DONE_BIT]         = m_done;
                val[CTRL_IDLE_BIT]         = m_idle;
                val[CTRL_AUTO_RESTART_BIT] = m_auto;
                m_done = 1'b0;
            end
            ADDR_GIE:           val[0]   = m_gie;
            ADDR_IER:           val[1:0] = m_ier;
            ADDR_ISR:           val[1:0] = m_isr;
            ADDR_INSTR_SCALAR:  val = m_instr[0];
            ADDR_INSTR_ADDR_L:  val = m_instr[1];
            ADDR_INSTR_ADDR_H:  val = m_instr[2];
            ADDR_INSTR_STATUS:  val = m_aux_status;
            ADDR_CORE_STATUS_0: val = m_core_status[0];
            ADDR_CORE_STATUS_1: val = m_core_status[1];
            default: begin
                if (addr >= ADDR_CORE_SCALAR_0 && addr <= ADDR_CORE_SCALAR_3)
                    val = m_core[core_index(addr)];
            end
        endcase
    endtask

    // ap_done or ap_ready pulse
    task automatic model_event(input logic is_done);
        if (is_done) begin
            m_done = 1'b1;
            if (!m_auto) m_start = 1'b0;
            m_isr[0] = m_isr[0] | m_ier[0];
        end else begin
            m_isr[1] = m_isr[1] | m_ier[1];
        end
    endtask

    function automatic addr64_t model_output(input addr_t addr);
        case (addr)
            ADDR_AP_CTRL:      return addr64_t'(m_start);
            ADDR_ISR:          return addr64_t'(m_gie && (|m_isr));
            ADDR_INSTR_SCALAR: return addr64_t'(m_instr[0]);
            ADDR_INSTR_ADDR_L: return {m_instr[2], m_instr[1]};
            default:           return addr64_t'(m_core[core_index(addr)]);
        endcase
    endfunction

    task automatic run_case(input string op, input addr_t addr, input word_t data,
                            input strb_t strb, input string name, input addr64_t exp);
        word_t rd_val;
        word_t mdl_word;
        if (op == "wr") begin
            axi_write(name, addr, data, strb);
            model_write(addr, data, strb);
        end else if (op == "rd") begin
            model_read(addr, mdl_word);
            check_model(name, exp, addr64_t'(mdl_word));
            axi_read(name, addr, rd_val);
            check_word(name, exp[DATA_W-1:0], rd_val);
            // core bank words also drive core_scalar
            if (addr >= ADDR_CORE_SCALAR_0 && addr <= ADDR_CORE_SCALAR_3) begin
                @(negedge clk);
                check_word(name, exp[DATA_W-1:0], core_scalar[core_index(addr)]);
            end
        end else if (op == "done" || op == "ready") begin
            @(posedge clk);
            ap_done  <= (op == "done");
            ap_ready <= (op == "ready");
            @(posedge clk);
            ap_done  <= 1'b0;
            ap_ready <= 1'b0;
            @(posedge clk);
            model_event(op == "done");
        end else if (op == "stat") begin
            @(posedge clk);
            case (addr)
                ADDR_AP_CTRL:       ap_idle <= data[0];
                ADDR_INSTR_STATUS:  aux_instr_status <= data;
                ADDR_CORE_STATUS_0: core_status[0] <= data;
                default:            core_status[1] <= data;
            endcase
            case (addr)
                ADDR_AP_CTRL:       m_idle = data[0];
                ADDR_INSTR_STATUS:  m_aux_status = data;
                ADDR_CORE_STATUS_0: m_core_status[0] = data;
                default:            m_core_status[1] = data;
            endcase
            repeat (2) @(posedge clk);
        end else if (op == "chk") begin
            check_model(name, exp, model_output(addr));
            @(negedge clk);
            case (addr)
                ADDR_AP_CTRL:      check_bit(name, exp[0], ap_start);
                ADDR_ISR:          check_bit(name, exp[0], interrupt);
                ADDR_INSTR_SCALAR: check_word(name, exp[DATA_W-1:0], aux_instr_scalar);
                ADDR_INSTR_ADDR_L: check_addr(name, exp, aux_instr_addr);
                default: check_word(name, exp[DATA_W-1:0], core_scalar[core_index(addr)]);
            endcase
        end else begin
            $display("unknown operation %s in test %s", op, name);
            case_failed = 1'b1;
        end
    endtask

    initial begin
        wait (cycle_limit > 0);
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout, the run went past %0d cycles", cycle_limit);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        int               fd;
        logic [8*128-1:0] line_buf;
        logic [8*8-1:0]   op;
        addr_t            addr;
        word_t            data;
        strb_t            strb;
        logic [8*32-1:0]  name;
        addr64_t          exp;
        rst_n            = 1'b0;
        awvalid          = 1'b0;
        awaddr           = '0;
        wvalid           = 1'b0;
        wdata            = '0;
        wstrb            = '0;
        bready           = 1'b0;
        arvalid          = 1'b0;
        araddr           = '0;
        rready           = 1'b0;
        ap_done          = 1'b0;
        ap_idle          = 1'b0;
        ap_ready         = 1'b0;
        aux_instr_status = '0;
        core_status      = '0;
        // model reset state
        {m_start, m_done, m_idle, m_auto, m_gie, m_ier, m_isr} = '0;
        m_instr         = '{32'hAAAA_0000, 32'hAAAA_0000, 32'h0000_0000};
        m_core          = '{default: '0};
        m_aux_status    = '0;
        m_core_status   = '{default: '0};
        fd = $fopen("sim/ps_ctrl_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open sim/ps_ctrl_cases.txt");
        end else begin
            while (!$feof(fd)) begin
                line_buf = '0;
                if ($fgets(line_buf, fd) > 0) begin
                    if ($sscanf(line_buf, "%s %h %h %h %s %h",
                                op, addr, data, strb, name, exp) == 6) begin
                        op_q.push_back(string'(op));
                        addr_q.push_back(addr);
                        data_q.push_back(data);
                        strb_q.push_back(strb);
                        name_q.push_back(string'(name));
                        exp_q.push_back(exp);
                    end
                end
            end
            $fclose(fd);
        end
        if (op_q.size() == 0) begin
            $display("no test cases were read");
            failures++;
        end
        cycle_limit = op_q.size() * CYCLES_PER_CASE + MAX_DELAY;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < op_q.size(); i++) begin
            case_failed = 1'b0;
            run_case(op_q[i], addr_q[i], data_q[i], strb_q[i], name_q[i], exp_q[i]);
            tests++;
            if (case_failed) failures++;
            $display("%s %s", case_failed ? "FAIL" : "ok  ", name_q[i]);
        end
        $display("tests %0d, passed %0d, failed %0d", tests, tests - failures, failures);
        if (failures == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
+incdir+sim
common/ps_ctrl_pkg.sv
axi_lite/axi_write_ctrl.sv
axi_lite/axi_read_ctrl.sv
regs/ap_ctrl_regs.sv
regs/user_reg_bank.sv
verilog/ps_ctrl_top.sv
sim/tb_ps_ctrl.sv

// File: verilog/ps_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module ps_ctrl_top (
    input  wire                        clk,
    input  wire                        rst_n,
    // AXI4-Lite write
    input  wire                        awvalid,
    output logic                       awready,
    input  ps_ctrl_pkg::addr_t         awaddr,
    input  wire                        wvalid,
    output logic                       wready,
    input  ps_ctrl_pkg::word_t         wdata,
    input  ps_ctrl_pkg::strb_t         wstrb,
    output logic                       bvalid,
    input  wire                        bready,
    output logic [1:0]                 bresp,
    // AXI4-Lite read
    input  wire                        arvalid,
    output logic                       arready,
    input  ps_ctrl_pkg::addr_t         araddr,
    output logic                       rvalid,
    input  wire                        rready,
    output ps_ctrl_pkg::word_t         rdata,
    output logic [1:0]                 rresp,
    // accelerator side
    output logic                       ap_start,
    input  wire                        ap_done,
    input  wire                        ap_idle,
    input  wire                        ap_ready,
    output logic                       interrupt,
    output ps_ctrl_pkg::word_t         aux_instr_scalar,
    output ps_ctrl_pkg::addr64_t       aux_instr_addr,
    input  ps_ctrl_pkg::word_t         aux_instr_status,
    output ps_ctrl_pkg::word_t [ps_ctrl_pkg::NUM_CORE_SCALARS-1:0] core_scalar,
    input  ps_ctrl_pkg::word_t [ps_ctrl_pkg::NUM_CORE_STATUS-1:0]  core_status
);
    import ps_ctrl_pkg::*;

    logic                        wr_en;
    reg_sel_e                    wr_sel;
    word_t                       wr_data;
    strb_t                       wr_strb;
    logic                        ctrl_read_pulse;
    word_t                       ctrl_word;
    word_t                       gie_word;
    word_t                       ier_word;
    word_t                       isr_word;
    word_t [NUM_INSTR_WORDS-1:0] instr_words;

    axi_write_ctrl u_write_ctrl (
        .clk     (clk),
        .rst_n   (rst_n),
        .awvalid (awvalid),
        .awready (awready),
        .awaddr  (awaddr),
        .wvalid  (wvalid),
        .wready  (wready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .bvalid  (bvalid),
        .bready  (bready),
        .bresp   (bresp),
        .wr_en   (wr_en),
        .wr_sel  (wr_sel),
        .wr_data (wr_data),
        .wr_strb (wr_strb)
    );

    ap_ctrl_regs u_ap_ctrl_regs (
        .clk             (clk),
        .rst_n           (rst_n),
        .wr_en           (wr_en),
        .wr_sel          (wr_sel),
        .wr_data         (wr_data),
        .wr_strb         (wr_strb),
        .ctrl_read_pulse (ctrl_read_pulse),
        .ap_done         (ap_done),
        .ap_idle         (ap_idle),
        .ap_ready        (ap_ready),
        .ap_start        (ap_start),
        .interrupt       (interrupt),
        .ctrl_word       (ctrl_word),
        .gie_word        (gie_word),
        .ier_word        (ier_word),
        .isr_word        (isr_word)
    );

    // scalar, addr low, addr high
    user_reg_bank #(
        .NUM_WORDS   (NUM_INSTR_WORDS),
        .FIRST_SEL   (SEL_INSTR_SCALAR),
        .RESET_WORDS (INSTR_RESET_WORDS)
    ) u_instr_bank (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (wr_en),
        .wr_sel  (wr_sel),
        .wr_data (wr_data),
        .wr_strb (wr_strb),
        .words   (instr_words)
    );

    user_reg_bank #(
        .NUM_WORDS   (NUM_CORE_SCALARS),
        .FIRST_SEL   (SEL_CORE_SCALAR_0),
        .RESET_WORDS ('0)
    ) u_core_bank (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (wr_en),
        .wr_sel  (wr_sel),
        .wr_data (wr_data),
        .wr_strb (wr_strb),
        .words   (core_scalar)
    );

    assign aux_instr_scalar = instr_words[0];
    assign aux_instr_addr   = {instr_words[2], instr_words[1]};

    axi_read_ctrl u_read_ctrl (
        .clk              (clk),
        .rst_n            (rst_n),
        .arvalid          (arvalid),
        .arready          (arready),
        .araddr           (araddr),
        .rvalid           (rvalid),
        .rready           (rready),
        .rdata            (rdata),
        .rresp            (rresp),
        .ctrl_read_pulse  (ctrl_read_pulse),
        .ctrl_word        (ctrl_word),
        .gie_word         (gie_word),
        .ier_word         (ier_word),
        .isr_word         (isr_word),
        .instr_words      (instr_words),
        .core_words       (core_scalar),
        .aux_instr_status (aux_instr_status),
        .core_status      (core_status)
    );

endmodule

`default_nettype wire
